// ==== build.f ====
+incdir+include
src/mc_csr_pkg.sv
src/mc_link_pkg.sv
src/mc_clock_gen.sv
src/mc_shift_reg.sv
src/mc_link_ctrl.sv
src/mc_csr.sv
src/memcard.sv
verification/mc_card_model.sv
verification/tb_memcard.sv

// ==== Bender.yml ====
package:
  name: memcard

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/mc_csr_pkg.sv
      - src/mc_link_pkg.sv
      - src/mc_clock_gen.sv
      - src/mc_shift_reg.sv
      - src/mc_link_ctrl.sv
      - src/mc_csr.sv
      - src/memcard.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/mc_card_model.sv
      - verification/tb_memcard.sv

// ==== verification/tb_memcard.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module tb_memcard;

	localparam int unsigned CLK_PERIOD_NS = 4;
	localparam int unsigned F_CMD = 3;
	localparam int unsigned F_DAT = 1;
	localparam int unsigned F_RX = 2;
	localparam int unsigned F_SLOW = 6;
	// 8 card clocks per transfer and two rounds in the receive test.
	localparam int unsigned WATCHDOG_CYCLES = 16 * (F_CMD + 1) + 16 * (F_DAT + 1)
		+ 32 * (F_RX + 1) + 16 * (F_SLOW + 1) + 2000;
	localparam int unsigned POLL_LIMIT = 1000;
	localparam logic [3:0] WRONG_PAGE = `MC_CSR_PAGE_DEFAULT ^ 4'h5;

	logic sys_clk;
	logic sys_rst;
	mc_csr_pkg::csr_addr_t csr_a;
	logic csr_we;
	mc_csr_pkg::csr_word_t csr_di;
	mc_csr_pkg::csr_word_t csr_do;
	logic irq;
	wire [3:0] mc_d;
	wire mc_cmd;
	logic mc_clk;
	logic [31:0] lfsr_state;

	memcard #(
		.csr_page(`MC_CSR_PAGE_DEFAULT)
	) u_dut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.irq(irq),
		.mc_d(mc_d),
		.mc_cmd(mc_cmd),
		.mc_clk(mc_clk)
	);

	mc_card_model u_card (
		.sys_clk(sys_clk),
		.mc_clk(mc_clk),
		.mc_cmd(mc_cmd),
		.mc_d(mc_d)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD_NS / 2) sys_clk = ~sys_clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD_NS);
		$display("the run timed out after %0d clock cycles", WATCHDOG_CYCLES);
		stop_on_failure();
	end

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------

	task automatic stop_on_failure();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s, got 0x%08h, expected 0x%08h",
				$time, what, actual, expected);
			stop_on_failure();
		end
	endtask

	// galois lfsr, x^32 + x^22 + x^2 + x + 1.
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
		return out;
	endfunction

	function automatic logic [31:0] random_bits(input int unsigned count);
		logic [31:0] value;
		value = '0;
		repeat (count)
			value = {value[30:0], lfsr_bit()};
		return value;
	endfunction

	function automatic mc_csr_pkg::csr_addr_t reg_addr(input logic [3:0] page,
		input logic [2:0] offset);
		return {page, 7'd0, offset};
	endfunction

	task automatic csr_write(input logic [2:0] offset, input logic [31:0] data);
		@(posedge sys_clk);
		#1;
		csr_a = reg_addr(`MC_CSR_PAGE_DEFAULT, offset);
		csr_we = 1'b1;
		csr_di = data;
		@(posedge sys_clk);
		#1;
		csr_we = 1'b0;
	endtask

	task automatic csr_read(input logic [3:0] page, input logic [2:0] offset,
		output logic [31:0] data);
		@(posedge sys_clk);
		#1;
		csr_a = reg_addr(page, offset);
		csr_we = 1'b0;
		@(posedge sys_clk);
		#1;
		data = csr_do; // registered one cycle after the address.
	endtask

	task automatic wait_pending(input logic [3:0] mask, input logic [3:0] value);
		logic [31:0] flags;
		int unsigned polls;
		polls = 0;
		csr_read(`MC_CSR_PAGE_DEFAULT, `MC_REG_PEND, flags);
		while ((flags[3:0] & mask) !== value) begin
			polls++;
			if (polls > POLL_LIMIT) begin
				$display("pending flags never reached %b under mask %b", value, mask);
				stop_on_failure();
			end
			csr_read(`MC_CSR_PAGE_DEFAULT, `MC_REG_PEND, flags);
		end
	endtask

	task automatic wait_event(input logic irq_wanted, input int unsigned rises);
		int unsigned cycles;
		cycles = 0;
		while ((irq_wanted && irq !== 1'b1) || u_card.rise_count < rises) begin
			cycles++;
			if (cycles > POLL_LIMIT) begin
				$display("the card clock or irq never reached the awaited state");
				stop_on_failure();
			end
			@(posedge sys_clk);
			#1;
		end
	endtask

	task automatic check_stalled(input int unsigned factor);
		int unsigned rises;
		logic level;
		rises = u_card.rise_count;
		level = mc_clk;
		repeat (4 * (factor + 1)) @(posedge sys_clk);
		#1;
		check_value(u_card.rise_count, rises, "card clock rises while stalled");
		check_value(mc_clk, level, "card clock level while stalled");
	endtask

	// ------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------

	task automatic reset_test();
		logic [31:0] data;
		check_value(mc_clk, 1'b0, "card clock after reset");
		check_value(irq, 1'b0, "irq after reset");
		check_value(csr_do, 32'h0, "read data after reset");
		check_value(mc_cmd, {31'd0, 1'bz}, "command pin released");
		check_value(mc_d, {28'd0, 4'bzzzz}, "data pins released");
		csr_read(`MC_CSR_PAGE_DEFAULT, `MC_REG_DIV, data);
		check_value(data, 32'd10, "divider factor after reset");
		for (int offset = `MC_REG_EN; offset <= `MC_REG_DAT; offset++) begin
			csr_read(`MC_CSR_PAGE_DEFAULT, offset[2:0], data);
			check_value(data, 32'h0, "register after reset");
		end
		csr_read(WRONG_PAGE, `MC_REG_DIV, data); // factor is nonzero here.
		check_value(data, 32'h0, "read from another page");
	endtask

	task automatic tx_test(input logic data_line, input int unsigned factor);
		logic [31:0] value;
		logic [31:0] data;
		value = data_line ? random_bits(32) : random_bits(8);
		csr_write(`MC_REG_EN, data_line ? 32'h4 : 32'h1); // idle transmitter stalls the clock.
		csr_write(`MC_REG_PEND, 32'hA);
		csr_write(`MC_REG_DIV, factor);
		u_card.clear_record();
		csr_write(data_line ? `MC_REG_DAT : `MC_REG_CMD, value);
		wait_pending(data_line ? 4'h4 : 4'h1, 4'h0);
		check_stalled(factor);
		check_value(u_card.rise_count, 8, "card clock rises per transfer");
		check_value(u_card.min_period, 2 * (factor + 1), "shortest card clock period");
		check_value(u_card.max_period, 2 * (factor + 1), "longest card clock period");
		if (data_line)
			check_value(u_card.dat_rec, value, "nibbles seen by the card");
		else
			check_value(u_card.cmd_rec, value, "bits seen by the card");
		csr_read(`MC_CSR_PAGE_DEFAULT, `MC_REG_DIV, data);
		check_value(data, factor, "divider factor readback");
	endtask

	task automatic rx_test();
		logic [31:0] cmd_value;
		logic [31:0] dat_value;
		logic [31:0] data;
		cmd_value = random_bits(8);
		dat_value = random_bits(32);
		csr_write(`MC_REG_EN, 32'h1); // stall first, so counting starts cleanly.
		csr_write(`MC_REG_PEND, 32'hA);
		csr_write(`MC_REG_DIV, F_RX);
		csr_write(`MC_REG_EN, 32'hA);
		u_card.clear_record();
		u_card.start_rx(cmd_value[7:0], dat_value);
		wait_event(1'b1, 0);
		csr_read(`MC_CSR_PAGE_DEFAULT, `MC_REG_PEND, data);
		check_value(data, 32'hA, "pending after receive");
		check_value(irq, 1'b1, "irq with received data");
		check_value(u_card.rise_count, 8, "card clock rises per receive");
		check_stalled(F_RX);
		csr_read(`MC_CSR_PAGE_DEFAULT, `MC_REG_CMD, data);
		check_value(data, cmd_value, "received command byte");
		csr_read(`MC_CSR_PAGE_DEFAULT, `MC_REG_DAT, data);
		check_value(data, dat_value, "received data word");
		u_card.clear_record();
		csr_write(`MC_REG_PEND, 32'hA);
		check_value(irq, 1'b0, "irq after clear");
		wait_event(1'b0, 1); // clock runs again.
		u_card.stop_rx();
	endtask

	initial begin
		sys_rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		lfsr_state = 32'd78564;
		repeat (5) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		reset_test();
		tx_test(1'b0, F_CMD);
		tx_test(1'b1, F_DAT);
		rx_test();
		tx_test(1'b0, F_SLOW); // new factor written while the clock is stalled.
		$display("Test OK");
		$finish;
	end

endmodule

// ==== verification/mc_card_model.sv ====
`timescale 1ns/1ps

module mc_card_model (
	input logic sys_clk,
	input logic mc_clk,
	inout wire mc_cmd,
	inout wire [3:0] mc_d
);

	logic clk_seen; // levels seen at the previous falling sys_clk edge.
	logic cmd_seen;
	logic [3:0] dat_seen;
	logic rx_drive;
	logic rx_used; // a rise has taken the bits now on the pins.
	logic [7:0] rx_cmd;
	logic [31:0] rx_dat;
	logic [7:0] cmd_rec;
	logic [31:0] dat_rec;
	int unsigned cycle;
	int unsigned last_rise;
	int unsigned rise_count;
	int unsigned min_period;
	int unsigned max_period;

	// receive bits go out most significant first.
	assign mc_cmd = rx_drive ? rx_cmd[7] : 1'bz;
	assign mc_d = rx_drive ? rx_dat[31:28] : 4'bzzzz;

	task automatic clear_record();
		rise_count = 0;
		min_period = '1;
		max_period = 0;
		cmd_rec = '0;
		dat_rec = '0;
	endtask

	task automatic start_rx(input logic [7:0] cmd_value, input logic [31:0] dat_value);
		rx_cmd = cmd_value;
		rx_dat = dat_value;
		rx_used = 1'b0;
		rx_drive = 1'b1;
	endtask

	task automatic stop_rx();
		rx_drive = 1'b0;
	endtask

	initial begin
		clk_seen = 1'b0;
		cmd_seen = 1'b0;
		dat_seen = '0;
		cycle = 0;
		last_rise = 0;
		rx_cmd = '0;
		rx_dat = '0;
		rx_used = 1'b0;
		stop_rx();
		clear_record();
	end

	// ------------------------------------------------------------------
	// sampled mid-cycle, away from the edge that moves the pins
	// ------------------------------------------------------------------

	always @(negedge sys_clk) begin
		int unsigned period;
		period = cycle - last_rise;
		if (mc_clk && !clk_seen) begin
			cmd_rec = {cmd_rec[6:0], cmd_seen}; // levels held just before the rise.
			dat_rec = {dat_rec[27:0], dat_seen};
			if (rise_count > 0) begin
				if (period < min_period)
					min_period = period;
				if (period > max_period)
					max_period = period;
			end
			last_rise = cycle;
			rise_count++;
			rx_used = 1'b1;
		end else if (!mc_clk && clk_seen && rx_used) begin
			rx_cmd = {rx_cmd[6:0], 1'b0}; // next bit after the fall.
			rx_dat = {rx_dat[27:0], 4'h0};
			rx_used = 1'b0;
		end
		clk_seen = mc_clk;
		cmd_seen = mc_cmd;
		dat_seen = mc_d;
		cycle++;
	end

endmodule

// ==== src/memcard.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module memcard #(
	parameter logic [3:0] csr_page = `MC_CSR_PAGE_DEFAULT
) (
	input logic sys_clk,
	input logic sys_rst,
	input mc_csr_pkg::csr_addr_t csr_a,
	input logic csr_we,
	input mc_csr_pkg::csr_word_t csr_di,
	output mc_csr_pkg::csr_word_t csr_do,
	output logic irq,
	inout wire [3:0] mc_d,
	inout wire mc_cmd,
	output logic mc_clk
);

	mc_csr_pkg::div_factor_t div_factor;
	mc_csr_pkg::chan_flags_t enables;
	mc_csr_pkg::chan_flags_t pending;
	mc_csr_pkg::csr_word_t load_value;
	mc_link_pkg::cmd_byte_t cmd_word;
	mc_link_pkg::dat_word_t dat_word;
	logic cmd_load;
	logic dat_load;
	logic cmd_rx_clear;
	logic dat_rx_clear;
	logic clock_run;
	logic bit_ce;
	logic [0:0] cmd_pin;
	logic [3:0] dat_pin;

	// ------------------------------------------------------------------
	// control path
	// ------------------------------------------------------------------

	mc_csr #(
		.csr_page(csr_page)
	) u_csr (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.pending(pending),
		.cmd_word(cmd_word),
		.dat_word(dat_word),
		.csr_do(csr_do),
		.div_factor(div_factor),
		.enables(enables),
		.cmd_load(cmd_load),
		.dat_load(dat_load),
		.load_value(load_value),
		.cmd_rx_clear(cmd_rx_clear),
		.dat_rx_clear(dat_rx_clear)
	);

	mc_link_ctrl u_link_ctrl (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.enables(enables),
		.bit_ce(bit_ce),
		.cmd_load(cmd_load),
		.dat_load(dat_load),
		.cmd_rx_clear(cmd_rx_clear),
		.dat_rx_clear(dat_rx_clear),
		.pending(pending),
		.clock_run(clock_run),
		.irq(irq)
	);

	mc_clock_gen u_clock_gen (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.div_factor(div_factor),
		.clock_run(clock_run),
		.mc_clk(mc_clk),
		.bit_ce(bit_ce)
	);

	// ------------------------------------------------------------------
	// shifters, sampling straight from the pins
	// ------------------------------------------------------------------

	mc_shift_reg #(
		.lanes(1),
		.depth(8)
	) u_cmd_shift (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.load(cmd_load),
		.load_value(load_value[7:0]),
		.shift(bit_ce),
		.pin_in(mc_cmd),
		.word(cmd_word),
		.pin_out(cmd_pin)
	);

	mc_shift_reg #(
		.lanes(4),
		.depth(32)
	) u_dat_shift (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.load(dat_load),
		.load_value(load_value),
		.shift(bit_ce),
		.pin_in(mc_d),
		.word(dat_word),
		.pin_out(dat_pin)
	);

	// pins are only driven while the matching transmitter is enabled.
	assign mc_cmd = enables[mc_csr_pkg::CH_CMD_TX] ? cmd_pin[0] : 1'bz;
	assign mc_d = enables[mc_csr_pkg::CH_DAT_TX] ? dat_pin : 4'bzzzz;

endmodule

// ==== src/mc_csr.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module mc_csr #(
	parameter logic [3:0] csr_page = `MC_CSR_PAGE_DEFAULT
) (
	input logic sys_clk,
	input logic sys_rst,
	input mc_csr_pkg::csr_addr_t csr_a,
	input logic csr_we,
	input mc_csr_pkg::csr_word_t csr_di,
	input mc_csr_pkg::chan_flags_t pending,
	input mc_link_pkg::cmd_byte_t cmd_word,
	input mc_link_pkg::dat_word_t dat_word,
	output mc_csr_pkg::csr_word_t csr_do,
	output mc_csr_pkg::div_factor_t div_factor,
	output mc_csr_pkg::chan_flags_t enables,
	output logic cmd_load,
	output logic dat_load,
	output mc_csr_pkg::csr_word_t load_value,
	output logic cmd_rx_clear,
	output logic dat_rx_clear
);

	logic selected;
	logic [2:0] offset;
	logic write;

	// ------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------

	assign selected = csr_a[13:10] == csr_page;
	assign offset = csr_a[2:0]; // bits [9:3] are not decoded.
	assign write = selected & csr_we;

	// ------------------------------------------------------------------
	// configuration registers
	// ------------------------------------------------------------------

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			div_factor <= `MC_DIV_RESET;
			enables <= '0;
		end else if (write) begin
			case (offset)
				`MC_REG_DIV: div_factor <= csr_di[10:0];
				`MC_REG_EN: enables <= csr_di[3:0];
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// read multiplexer
	// ------------------------------------------------------------------

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else if (selected) begin
			case (offset)
				`MC_REG_DIV: csr_do <= mc_csr_pkg::csr_word_t'(div_factor);
				`MC_REG_EN: csr_do <= mc_csr_pkg::csr_word_t'(enables);
				`MC_REG_PEND: csr_do <= mc_csr_pkg::csr_word_t'(pending);
				`MC_REG_CMD: csr_do <= mc_csr_pkg::csr_word_t'(cmd_word);
				`MC_REG_DAT: csr_do <= dat_word;
				default: csr_do <= '0;
			endcase
		end else begin
			csr_do <= '0; // other pages read as zero.
		end
	end

	// ------------------------------------------------------------------
	// write strobes
	// ------------------------------------------------------------------

	// single cycle, as the host holds a write for one cycle only.
	assign cmd_load = write & (offset == `MC_REG_CMD);
	assign dat_load = write & (offset == `MC_REG_DAT);
	assign load_value = csr_di; // shifters take the low bits they need.

	// write one to clear the receive flags.
	assign cmd_rx_clear = write & (offset == `MC_REG_PEND) & csr_di[1];
	assign dat_rx_clear = write & (offset == `MC_REG_PEND) & csr_di[3];

endmodule

// ==== src/mc_link_ctrl.sv ====
`timescale 1ns/1ps

module mc_link_ctrl (
	input logic sys_clk,
	input logic sys_rst,
	input mc_csr_pkg::chan_flags_t enables,
	input logic bit_ce,
	input logic cmd_load,
	input logic dat_load,
	input logic cmd_rx_clear,
	input logic dat_rx_clear,
	output mc_csr_pkg::chan_flags_t pending,
	output logic clock_run,
	output logic irq
);

	localparam mc_link_pkg::cmd_count_t CMD_LAST = 3'd7;
	localparam mc_link_pkg::dat_count_t DAT_LAST = 5'd28; // last nibble of 32 bits.
	localparam mc_link_pkg::dat_count_t DAT_STEP = 5'd4;

	mc_link_pkg::chan_state_t cmd_state;
	mc_link_pkg::chan_state_t dat_state;
	mc_link_pkg::cmd_count_t cmd_count;
	mc_link_pkg::dat_count_t dat_count;
	logic cmd_step;
	logic dat_step;
	logic cmd_done;
	logic dat_done;

	// a line counts when either of its directions is enabled.
	assign cmd_step = bit_ce & (cmd_state != mc_link_pkg::CH_HELD)
		& (enables[mc_csr_pkg::CH_CMD_TX] | enables[mc_csr_pkg::CH_CMD_RX]);
	assign dat_step = bit_ce & (dat_state != mc_link_pkg::CH_HELD)
		& (enables[mc_csr_pkg::CH_DAT_TX] | enables[mc_csr_pkg::CH_DAT_RX]);

	assign cmd_done = cmd_step & (cmd_count == CMD_LAST);
	assign dat_done = dat_step & (dat_count == DAT_LAST);

	// ------------------------------------------------------------------
	// line state machines and bit counters
	// ------------------------------------------------------------------

	always_ff @(posedge sys_clk) begin
		if (sys_rst | cmd_load | cmd_rx_clear) begin
			cmd_state <= mc_link_pkg::CH_IDLE;
			cmd_count <= '0;
		end else if (cmd_step) begin
			cmd_count <= cmd_count + 3'd1;
			cmd_state <= cmd_done ? mc_link_pkg::CH_HELD : mc_link_pkg::CH_SHIFT;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst | dat_load | dat_rx_clear) begin
			dat_state <= mc_link_pkg::CH_IDLE;
			dat_count <= '0;
		end else if (dat_step) begin
			dat_count <= dat_count + DAT_STEP;
			dat_state <= dat_done ? mc_link_pkg::CH_HELD : mc_link_pkg::CH_SHIFT;
		end
	end

	// ------------------------------------------------------------------
	// pending flags
	// ------------------------------------------------------------------

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pending <= '0;
		end else begin
			if (cmd_load)
				pending[mc_csr_pkg::CH_CMD_TX] <= 1'b1;
			else if (cmd_done & enables[mc_csr_pkg::CH_CMD_TX])
				pending[mc_csr_pkg::CH_CMD_TX] <= 1'b0;

			if (cmd_rx_clear)
				pending[mc_csr_pkg::CH_CMD_RX] <= 1'b0;
			else if (cmd_done & enables[mc_csr_pkg::CH_CMD_RX])
				pending[mc_csr_pkg::CH_CMD_RX] <= 1'b1;

			if (dat_load)
				pending[mc_csr_pkg::CH_DAT_TX] <= 1'b1;
			else if (dat_done & enables[mc_csr_pkg::CH_DAT_TX])
				pending[mc_csr_pkg::CH_DAT_TX] <= 1'b0;

			if (dat_rx_clear)
				pending[mc_csr_pkg::CH_DAT_RX] <= 1'b0;
			else if (dat_done & enables[mc_csr_pkg::CH_DAT_RX])
				pending[mc_csr_pkg::CH_DAT_RX] <= 1'b1;
		end
	end

	// stall while a transmitter has nothing to send or a receiver is full.
	assign clock_run = ~((enables[mc_csr_pkg::CH_CMD_TX] & ~pending[mc_csr_pkg::CH_CMD_TX])
		| (enables[mc_csr_pkg::CH_CMD_RX] & pending[mc_csr_pkg::CH_CMD_RX])
		| (enables[mc_csr_pkg::CH_DAT_TX] & ~pending[mc_csr_pkg::CH_DAT_TX])
		| (enables[mc_csr_pkg::CH_DAT_RX] & pending[mc_csr_pkg::CH_DAT_RX]));

	assign irq = pending[mc_csr_pkg::CH_CMD_RX] | pending[mc_csr_pkg::CH_DAT_RX];

endmodule

// ==== src/mc_shift_reg.sv ====
`timescale 1ns/1ps

module mc_shift_reg #(
	parameter int unsigned lanes = 1,
	parameter int unsigned depth = 8
) (
	input logic sys_clk,
	input logic sys_rst,
	input logic load,
	input logic [depth-1:0] load_value,
	input logic shift,
	input logic [lanes-1:0] pin_in,
	output logic [depth-1:0] word,
	output logic [lanes-1:0] pin_out
);

	// the word doubles as the readback register.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			word <= '0;
		end else if (load) begin
			word <= load_value; // a host write wins over a shift.
		end else if (shift) begin
			// pins enter at the bottom. when transmitting, the pin
			// carries our own top lane, so the word rotates.
			word <= {word[depth-lanes-1:0], pin_in};
		end
	end

	// most significant lanes go out first.
	assign pin_out = word[depth-1 -: lanes];

endmodule

// ==== src/mc_clock_gen.sv ====
`timescale 1ns/1ps

module mc_clock_gen (
	input logic sys_clk,
	input logic sys_rst,
	input mc_csr_pkg::div_factor_t div_factor,
	input logic clock_run,
	output logic mc_clk,
	output logic bit_ce
);

	mc_csr_pkg::div_factor_t tick_count;
	logic tick; // one cycle every div_factor+1 cycles.

	// ------------------------------------------------------------------
	// half-period tick
	// ------------------------------------------------------------------

	// free running, so the tick phase does not depend on clock_run.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			tick_count <= '0;
			tick <= 1'b0;
		end else if (tick_count >= div_factor) begin
			tick_count <= '0; // >= so a smaller factor takes effect at once.
			tick <= 1'b1;
		end else begin
			tick_count <= tick_count + 1'b1;
			tick <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// card clock
	// ------------------------------------------------------------------

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			mc_clk <= 1'b0;
		else if (tick & clock_run)
			mc_clk <= ~mc_clk; // frozen in place while stalled.
	end

	// high in the cycle whose edge raises mc_clk.
	assign bit_ce = tick & clock_run & ~mc_clk;

endmodule

// ==== src/mc_link_pkg.sv ====
package mc_link_pkg;

	// ------------------------------------------------------------------
	// shift words and bit counters
	// ------------------------------------------------------------------

	typedef logic [7:0] cmd_byte_t; // command line, one bit per clock.
	typedef logic [31:0] dat_word_t; // data lines, one nibble per clock.

	typedef logic [2:0] cmd_count_t; // counts command bits.
	typedef logic [4:0] dat_count_t; // counts data bits, four at a time.

	// ------------------------------------------------------------------
	// per-line channel state
	// ------------------------------------------------------------------

	// idle until the first bit, shift while bits remain, then held
	// until software loads new data or clears the receive flag.
	typedef enum logic [1:0] {
		CH_IDLE  = 2'd0,
		CH_SHIFT = 2'd1,
		CH_HELD  = 2'd2
	} chan_state_t;

endpackage

// ==== src/mc_csr_pkg.sv ====
package mc_csr_pkg;

	// ------------------------------------------------------------------
	// register port types
	// ------------------------------------------------------------------

	typedef logic [13:0] csr_addr_t; // page in [13:10], offset in [2:0].
	typedef logic [31:0] csr_word_t;

	// half-period of the card clock, minus one, in sys_clk cycles.
	typedef logic [10:0] div_factor_t;

	// one bit per channel, used for enables and pending flags.
	typedef logic [3:0] chan_flags_t;

	// ------------------------------------------------------------------
	// bit positions inside chan_flags_t
	// ------------------------------------------------------------------

	localparam int unsigned CH_CMD_TX = 0;
	localparam int unsigned CH_CMD_RX = 1;
	localparam int unsigned CH_DAT_TX = 2;
	localparam int unsigned CH_DAT_RX = 3;

endpackage

// ==== include/mc_defines.svh ====
`ifndef MC_DEFINES_SVH
`define MC_DEFINES_SVH

// ----------------------------------------------------------------------
// csr page and reset values
// ----------------------------------------------------------------------

`define MC_CSR_PAGE_DEFAULT 4'h0 // matched against csr_a[13:10].
`define MC_DIV_RESET        11'd10 // half-period factor after reset.

// ----------------------------------------------------------------------
// register offsets, csr_a[2:0]
// ----------------------------------------------------------------------

`define MC_REG_DIV  3'd0 // clock divider factor.
`define MC_REG_EN   3'd1 // channel enables.
`define MC_REG_PEND 3'd2 // pending flags, write 1 to clear rx.
`define MC_REG_CMD  3'd3 // command byte.
`define MC_REG_DAT  3'd4 // data word.

`endif
